//--- design/armIsaPkg.sv
// Instruction formats of the ARM-style ISA, shared by the expander and its testbench
`include "uop_cfg.svh"

package armIsaPkg;

	// Condition field, bits 31:28
	typedef enum logic [3:0] {
		condEq = 4'b0000, condNe = 4'b0001, condCs = 4'b0010, condCc = 4'b0011,
		condMi = 4'b0100, condPl = 4'b0101, condVs = 4'b0110, condVc = 4'b0111,
		condHi = 4'b1000, condLs = 4'b1001, condGe = 4'b1010, condLt = 4'b1011,
		condGt = 4'b1100, condLe = 4'b1101, condAl = 4'b1110, condNv = 4'b1111
	} condT;

	// Data processing, register or immediate operand2
	typedef struct packed {
		condT                  cond;
		logic [2:0]            cls;       // 000 register, 001 immediate
		logic [3:0]            opcode;
		logic                  s;         // Set flags
		logic [`REG_IDX_W-1:0] rn;
		logic [`REG_IDX_W-1:0] rd;
		logic [11:0]           operand2;  // Shift and Rm, or rotated immediate
	} dpInstrT;

	// Single word or byte transfer
	typedef struct packed {
		condT                  cond;
		logic [2:0]            cls;       // 010 immediate offset
		logic                  p;         // Preindex
		logic                  u;         // Add offset
		logic                  b;         // Byte access
		logic                  w;         // Base writeback
		logic                  l;         // Load
		logic [`REG_IDX_W-1:0] rn;
		logic [`REG_IDX_W-1:0] rd;
		logic [11:0]           offset12;
	} memInstrT;

	// Load/store multiple
	typedef struct packed {
		condT                  cond;
		logic [2:0]            cls;       // 100
		logic                  p;         // Before
		logic                  u;         // Increment
		logic                  s;
		logic                  w;
		logic                  l;
		logic [`REG_IDX_W-1:0] rn;
		logic [`NUM_REGS-1:0]  regList;   // Bit i set means Ri transfers
	} blockInstrT;

	// Branch, with or without link
	typedef struct packed {
		condT        cond;
		logic [2:0]  cls;                 // 101
		logic        link;
		logic [23:0] offset24;
	} branchInstrT;

	// One decode word, four readings
	typedef union packed {
		dpInstrT     dp;
		memInstrT    mem;
		blockInstrT  block;
		branchInstrT branch;
	} armInstrT;

	localparam logic [3:0] opMov = 4'b1101;
	localparam logic [3:0] opAdd = 4'b0100;

endpackage

//--- design/blockXferPlanner.sv
// Register-list bookkeeping for LDM/STM expansion: next register, remaining count, start offset
`timescale 1ns/1ps
`include "uop_cfg.svh"

module blockXferPlanner (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  stall,
	input  logic                  first,        // Sequencer in ready
	input  logic [`INSTR_W-1:0]   instrD,
	output logic [`REG_IDX_W-1:0] nextReg,
	output logic [11:0]           startOffset,
	output logic                  addOffset,    // U bit of the first transfer
	output logic                  lastXfer,
	output logic                  noneLeft,
	output logic                  listEmpty
);
	localparam int CNT_W = $clog2(`NUM_REGS + 1);

	armIsaPkg::armInstrT  instrView;
	logic [`NUM_REGS-1:0] remList;      // Registers still to transfer
	logic [`NUM_REGS-1:0] activeList;   // List the current micro-op draws from
	logic [CNT_W-1:0]     xferCount;

	assign instrView = instrD;
	assign activeList = first ? instrView.block.regList : remList;  // Fresh list in ready
	assign listEmpty = (instrView.block.regList == '0);

	assign xferCount = CNT_W'($countones(activeList));
	assign lastXfer = (xferCount == CNT_W'(1));
	assign noneLeft = (xferCount == '0);

	// Lowest set register goes first
	always_comb begin
		nextReg = '0;
		for (int i = `NUM_REGS - 1; i >= 0; i--) begin
			if (activeList[i]) begin
				nextReg = i[`REG_IDX_W-1:0];
			end
		end
	end

	// Start offset and direction by addressing mode {P,U}
	always_comb begin
		unique case ({instrView.block.p, instrView.block.u})
			2'b00: begin  // DA
				startOffset = 12'((xferCount - 1) * `WORD_BYTES);
				addOffset = 1'b0;
			end
			2'b01: begin  // IA
				startOffset = '0;
				addOffset = 1'b1;
			end
			2'b10: begin  // DB
				startOffset = 12'(xferCount * `WORD_BYTES);
				addOffset = 1'b0;
			end
			2'b11: begin  // IB
				startOffset = 12'(`WORD_BYTES);
				addOffset = 1'b1;
			end
		endcase
	end

	// Drop the register just issued, hold under stall
	always_ff @(posedge clk) begin
		if (reset) begin
			remList <= '0;
		end else if (!stall) begin
			remList <= activeList & (activeList - 1'b1);  // Clear lowest set bit
		end
	end

endmodule

//--- design/condCheck.sv
// Evaluates an ARM condition field against the NZCV flags for the block-transfer cancel
`timescale 1ns/1ps

module condCheck (
	input  armIsaPkg::condT cond,
	input  logic [3:0]      flags,     // NZCV
	output logic            condPass
);
	logic n, z, c, v;

	assign {n, z, c, v} = flags;

	always_comb begin
		unique case (cond)
			armIsaPkg::condEq: condPass = z;
			armIsaPkg::condNe: condPass = !z;
			armIsaPkg::condCs: condPass = c;
			armIsaPkg::condCc: condPass = !c;
			armIsaPkg::condMi: condPass = n;
			armIsaPkg::condPl: condPass = !n;
			armIsaPkg::condVs: condPass = v;
			armIsaPkg::condVc: condPass = !v;
			armIsaPkg::condHi: condPass = c && !z;
			armIsaPkg::condLs: condPass = !c || z;
			armIsaPkg::condGe: condPass = (n == v);
			armIsaPkg::condLt: condPass = (n != v);
			armIsaPkg::condGt: condPass = !z && (n == v);
			armIsaPkg::condLe: condPass = z || (n != v);
			// Never passes as always, the null op still carries it
			armIsaPkg::condAl, armIsaPkg::condNv: condPass = 1'b1;
		endcase
	end

endmodule

//--- design/uopExpander.sv
// Top of the decode-stage micro-op expander, joining the FSM, list planner and condition check
`timescale 1ns/1ps
`include "uop_cfg.svh"

module uopExpander (
	input  logic                clk,
	input  logic                reset,
	input  logic [`INSTR_W-1:0] instrD,
	input  logic                stall,
	input  logic [3:0]          flags,          // NZCV
	output logic                uopSel,
	output logic                uopBusy,
	output logic                noFlagUpdate,
	output logic                prevRsr,
	output logic                blockForward,
	output uopPkg::rfOverrideT  regFileRz,
	output logic [`INSTR_W-1:0] uopInstr
);
	logic                  first;
	logic                  condPass;
	logic [`REG_IDX_W-1:0] nextReg;
	logic [11:0]           startOffset;
	logic                  addOffset, lastXfer, noneLeft, listEmpty;

	condCheck condCheck_i (
		.cond    (armIsaPkg::condT'(instrD[31:28])),
		.flags   (flags),
		.condPass(condPass)
	);

	blockXferPlanner blockXferPlanner_i (
		.clk(clk), .reset(reset), .stall(stall), .first(first), .instrD(instrD),
		.nextReg(nextReg), .startOffset(startOffset), .addOffset(addOffset),
		.lastXfer(lastXfer), .noneLeft(noneLeft), .listEmpty(listEmpty)
	);

	uopSequencer uopSequencer_i (
		.clk(clk), .reset(reset), .stall(stall), .instrD(instrD), .condPass(condPass),
		.nextReg(nextReg), .startOffset(startOffset), .addOffset(addOffset),
		.lastXfer(lastXfer), .noneLeft(noneLeft), .listEmpty(listEmpty),
		.uopSel(uopSel), .uopBusy(uopBusy), .noFlagUpdate(noFlagUpdate), .prevRsr(prevRsr),
		.blockForward(blockForward), .regFileRz(regFileRz), .uopInstr(uopInstr),
		.first(first)
	);

endmodule

//--- design/uopPkg.sv
// Sequencer state and register-file override types of the micro-op expander
package uopPkg;

	// Expansion FSM states
	typedef enum logic [2:0] {
		ready,      // Pass-through, or first micro-op of a sequence
		rsrSecond,  // Original op reading Rz
		blSecond,   // Branch with the link bit cleared
		ldmRun,     // Remaining loads
		stmRun      // Remaining stores
	} seqStateT;

	// Steers register-file ports toward Rz
	typedef struct packed {
		logic ra1Sel;   // First read port takes the Rm field
		logic wa3High;  // Write address high bit
		logic ra2High;  // Read port 2 high bit
		logic ra1High;  // Read port 1 high bit
	} rfOverrideT;

endpackage

//--- design/uopSequencer.sv
// Micro-op FSM of the decode stage that expands RSR, BL and LDM/STM into single-pass micro-ops
`timescale 1ns/1ps
`include "uop_cfg.svh"

module uopSequencer (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  stall,
	input  logic [`INSTR_W-1:0]   instrD,
	input  logic                  condPass,
	input  logic [`REG_IDX_W-1:0] nextReg,
	input  logic [11:0]           startOffset,
	input  logic                  addOffset,
	input  logic                  lastXfer,
	input  logic                  noneLeft,
	input  logic                  listEmpty,
	output logic                  uopSel,        // Micro-op replaces instrD
	output logic                  uopBusy,       // Hold fetch and decode
	output logic                  noFlagUpdate,
	output logic                  prevRsr,
	output logic                  blockForward,  // Chain address from previous micro-op
	output uopPkg::rfOverrideT    regFileRz,
	output logic [`INSTR_W-1:0]   uopInstr,
	output logic                  first
);
	uopPkg::seqStateT    state, nextState;
	armIsaPkg::armInstrT instr;   // Decoded views of instrD
	armIsaPkg::armInstrT uop;     // Micro-op under construction
	logic                bxLike;
	logic                isRsr, isBl, isBlock;

	assign instr = instrD;
	assign first = (state == uopPkg::ready);

	// BX and BLX register forms share the RSR bit pattern
	assign bxLike = (instrD[27:8] == 20'h12FFF) && !instrD[6];
	assign isRsr = (instr.dp.cls == 3'b000) && !instrD[7] && instrD[4] && !bxLike;
	assign isBl = (instr.branch.cls == 3'b101) && instr.branch.link;
	assign isBlock = (instr.block.cls == 3'b100) && !listEmpty;  // Empty list passes through

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= uopPkg::ready;
		end else if (!stall) begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = uopPkg::ready;
		uopSel = 1'b0;
		uopBusy = 1'b0;
		noFlagUpdate = 1'b0;
		prevRsr = 1'b0;
		blockForward = 1'b0;
		regFileRz = '0;
		uop = instr;   // Pass-through by default
		unique case (state)
			uopPkg::ready: begin
				if (isRsr) begin
					nextState = uopPkg::rsrSecond;
					uopSel = 1'b1;
					uopBusy = 1'b1;
					noFlagUpdate = 1'b1;
					regFileRz = 4'b1100;          // Rm into port 1, write Rz
					uop.dp.opcode = armIsaPkg::opMov;
					uop.dp.s = 1'b0;
					uop.dp.rn = '0;               // SBZ
					uop.dp.rd = `RZ_REG;          // Rz = shifted operand
				end else if (isBl) begin
					nextState = uopPkg::blSecond;
					uopSel = 1'b1;
					uopBusy = 1'b1;
					uop.dp.cls = 3'b000;
					uop.dp.opcode = armIsaPkg::opMov;
					uop.dp.s = 1'b0;
					uop.dp.rn = '0;
					uop.dp.rd = `LR_REG;
					uop.dp.operand2 = {8'b0, 4'hF};  // R15, unshifted
				end else if (isBlock) begin
					nextState = instr.block.l ? uopPkg::ldmRun : uopPkg::stmRun;
					uopSel = 1'b1;
					uopBusy = 1'b1;
					noFlagUpdate = 1'b1;
					uop.mem.cls = 3'b010;         // Immediate single transfer
					uop.mem.p = 1'b1;
					uop.mem.u = addOffset;
					uop.mem.b = 1'b0;             // Word
					uop.mem.w = 1'b0;
					uop.mem.rd = nextReg;         // Rn and L stay from instrD
					uop.mem.offset12 = startOffset;
				end
			end
			uopPkg::rsrSecond: begin
				uopSel = 1'b1;
				prevRsr = 1'b1;
				regFileRz = 4'b0010;              // Port 2 reads Rz
				uop.dp.operand2 = {8'b0, `RZ_REG};  // Plain Rz, no shift
			end
			uopPkg::blSecond: begin
				uopSel = 1'b1;
				uop.branch.link = 1'b0;
			end
			uopPkg::ldmRun, uopPkg::stmRun: begin
				uopSel = 1'b1;
				noFlagUpdate = 1'b1;
				if (!condPass || noneLeft) begin
					// Null op, R0 = R0 + 0 under the original condition
					uop.dp.cls = 3'b001;
					uop.dp.opcode = armIsaPkg::opAdd;
					uop.dp.s = 1'b0;
					uop.dp.rn = '0;
					uop.dp.rd = '0;
					uop.dp.operand2 = '0;
				end else begin
					nextState = lastXfer ? uopPkg::ready : state;
					uopBusy = !lastXfer;
					blockForward = 1'b1;
					regFileRz.ra1High = 1'b1;     // Base is Rz
					uop.mem.cls = 3'b010;
					uop.mem.p = 1'b1;
					uop.mem.u = 1'b1;
					uop.mem.b = 1'b0;
					uop.mem.w = 1'b0;
					uop.mem.rn = `RZ_REG;
					uop.mem.rd = nextReg;
					uop.mem.offset12 = 12'(`WORD_BYTES);
				end
			end
			default: begin
				nextState = uopPkg::ready;
			end
		endcase
	end

	assign uopInstr = uop;

endmodule

//--- design/uop_cfg.svh
// Widths and fixed register numbers of the micro-op expander, included by the RTL and testbench
`ifndef UOP_CFG_SVH
`define UOP_CFG_SVH

// Instruction word
`define INSTR_W 32

// Register file addressing
`define REG_IDX_W 4
`define NUM_REGS 16

// Scratch register Rz, reached as R15 in the field plus the high-bit override
`define RZ_REG 4'd15

// Link register written by the first BL micro-op
`define LR_REG 4'd14

// Address step between block transfers
`define WORD_BYTES 4

`endif

//--- src.f
+incdir+design
design/armIsaPkg.sv
design/uopPkg.sv
design/condCheck.sv
design/blockXferPlanner.sv
design/uopSequencer.sv
design/uopExpander.sv
verif/uopExpanderTb.sv

//--- verif/uopExpanderTb.sv
// Self-checking testbench of the micro-op expander that runs as top module uopExpanderTb from src.f
`timescale 1ns/1ps
`include "uop_cfg.svh"

module uopExpanderTb;
	localparam int MAX_CYCLES = 20000;  // Far above the length of all sequences and their stalls

	logic                clk, reset, stall;
	logic [`INSTR_W-1:0] instrD, uopInstr;
	logic [3:0]          flags;           // NZCV
	logic                uopSel, uopBusy, noFlagUpdate, prevRsr, blockForward;
	uopPkg::rfOverrideT  regFileRz;
	logic [31:0]         seed = 32'd15;   // LCG state
	int                  seqIdx = 0;      // Cycle index within the running sequence
	int                  errors = 0;
	int                  cycles = 0;

	uopExpander dut_i (
		.clk(clk), .reset(reset), .instrD(instrD), .stall(stall), .flags(flags),
		.uopSel(uopSel), .uopBusy(uopBusy), .noFlagUpdate(noFlagUpdate), .prevRsr(prevRsr),
		.blockForward(blockForward), .regFileRz(regFileRz), .uopInstr(uopInstr)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;  // 40 ns period
	end

	function logic [31:0] randWord();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed ^ (seed >> 16);  // Fold high bits into the weak low ones
	endfunction

	// ARM condition rules where odd codes negate the even ones and NV acts as AL
	function automatic logic condHolds(input logic [3:0] cond, input logic [3:0] nzcv);
		logic n, z, c, v, r;
		{n, z, c, v} = nzcv;
		case (cond[3:1])
			3'd0: r = z;
			3'd1: r = c;
			3'd2: r = n;
			3'd3: r = v;
			3'd4: r = c && !z;           // HI
			3'd5: r = (n == v);          // GE
			3'd6: r = !z && (n == v);    // GT
			default: r = 1'b1;
		endcase
		return (cond[0] && cond[3:1] != 3'd7) ? !r : r;
	endfunction

	// Register number of the k-th set bit counted from R0 up
	function automatic logic [3:0] nthReg(input logic [15:0] list, input int k);
		int seen;
		seen = 0;
		nthReg = 4'd0;
		for (int i = 0; i < 16; i++) begin
			if (list[i]) begin
				if (seen == k) nthReg = 4'(i);
				seen++;
			end
		end
	endfunction

	// Expected {sel, busy, noFlagUpdate, prevRsr, blockForward, regFileRz, uopInstr}
	function automatic logic [40:0] refModel(input logic [31:0] ins, input int idx,
			input logic [3:0] nzcv);
		logic [8:0]  ctl;
		logic [31:0] word;
		logic [11:0] offset;
		logic        bx;
		int          n;
		n = $countones(ins[15:0]);
		bx = (ins[27:8] == 20'h12FFF) && !ins[6];  // BX and BLX register forms
		ctl = '0;
		word = ins;
		if (ins[27:25] == 3'b000 && !ins[7] && ins[4] && !bx) begin  // RSR
			if (idx == 0) begin
				ctl = 9'b111_00_1100;
				word = {ins[31:25], 4'b1101, 1'b0, 4'h0, 4'hF, ins[11:0]};  // MOV of shifted Rm to Rz
			end else begin
				ctl = 9'b100_10_0010;
				word = {ins[31:12], 12'h00F};  // Operand2 is plain Rz
			end
		end else if (ins[27:25] == 3'b101 && ins[24]) begin  // BL
			if (idx == 0) begin
				ctl = 9'b110_00_0000;
				word = {ins[31:28], 3'b000, 4'b1101, 1'b0, 4'h0, 4'hE, 12'h00F};  // MOV of PC to LR
			end else begin
				ctl = 9'b100_00_0000;
				word[24] = 1'b0;
			end
		end else if (ins[27:25] == 3'b100 && n > 0) begin  // LDM/STM
			if (idx == 0) begin
				case (ins[24:23])
					2'b00: offset = 12'((n - 1) * `WORD_BYTES);  // DA
					2'b01: offset = 12'd0;                        // IA
					2'b10: offset = 12'(n * `WORD_BYTES);        // DB
					default: offset = 12'(`WORD_BYTES);          // IB
				endcase
				ctl = 9'b111_00_0000;
				word = {ins[31:28], 3'b010, 1'b1, ins[23], 2'b00, ins[20:16],
					nthReg(ins[15:0], 0), offset};
			end else if (!condHolds(ins[31:28], nzcv) || idx >= n) begin
				ctl = 9'b101_00_0000;
				word = {ins[31:28], 3'b001, 4'b0100, 1'b0, 8'h00, 12'h000};  // ADD of zero to R0
			end else begin
				ctl = {1'b1, idx != n - 1, 3'b101, 4'b0001};  // Base from Rz with chained address
				word = {ins[31:28], 3'b010, 2'b11, 2'b00, ins[20], 4'hF,
					nthReg(ins[15:0], idx), 12'(`WORD_BYTES)};
			end
		end
		return {ctl, word};
	endfunction

	// Drives one instruction with random stall cycles until its sequence ends
	task automatic runSequence(input logic [31:0] ins, input logic [3:0] flagsFirst,
			input logic [3:0] flagsRest);
		logic [40:0] expected;
		int          idx;
		idx = 0;
		do begin
			@(negedge clk);
			instrD = ins;
			flags = (idx == 0) ? flagsFirst : flagsRest;
			stall = (randWord() % 6 == 0);  // Spans of one or more stalled cycles
			seqIdx = idx;
			expected = refModel(ins, idx, flags);
			if (!stall) idx++;
		end while (stall || expected[39]);  // Busy low on a moving cycle ends it
	endtask

	// Compare in the middle of the low phase once inputs and state have settled
	initial begin
		logic [40:0] expected;
		forever begin
			@(negedge clk);
			#10;
			expected = refModel(instrD, seqIdx, flags);
			if (!reset && {uopSel, uopBusy, noFlagUpdate, prevRsr, blockForward,
					regFileRz} !== expected[40:32]) begin
				errors++;
				$display("error at %0t ns: control of %h step %0d expected %b got %b", $time,
					instrD, seqIdx, expected[40:32],
					{uopSel, uopBusy, noFlagUpdate, prevRsr, blockForward, regFileRz});
			end
			if (!reset && uopInstr !== expected[31:0]) begin
				errors++;
				$display("error at %0t ns: uop of %h step %0d expected %h got %h", $time,
					instrD, seqIdx, expected[31:0], uopInstr);
			end
		end
	end

	always @(posedge clk) cycles <= cycles + 1;

	initial begin
		wait (cycles == MAX_CYCLES);
		$display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		logic [31:0] w, f;
		reset = 1'b1;
		stall = 1'b0;
		instrD = '0;
		flags = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		repeat (200) begin  // Non-expanding words including empty block lists
			w = randWord();
			f = randWord();
			if (w[27:25] == 3'b000 || w[27:25] == 3'b101) w[27:25] = 3'b001;
			if (w[27:25] == 3'b100) w[15:0] = '0;
			runSequence(w, f[3:0], f[3:0]);
		end
		for (int k = 0; k < 100; k++) begin  // RSR with BX and BLX now and then
			w = randWord();
			f = randWord();
			w[27:25] = 3'b000;
			w[7] = 1'b0;
			w[4] = 1'b1;
			if (k % 10 == 0) w[27:4] = {20'h12FFF, 4'h1 | {2'b00, w[5], 1'b0}};
			runSequence(w, f[3:0], f[3:0]);
		end
		repeat (100) begin  // BL
			w = randWord();
			f = randWord();
			w[27:24] = 4'b1011;
			runSequence(w, f[3:0], f[3:0]);
		end
		for (int k = 0; k < 160; k++) begin  // LDM/STM with one register in every fourth
			w = randWord();
			f = randWord();
			w[27:25] = 3'b100;
			if (k % 4 == 0 || w[15:0] == '0) w[15:0] = 16'h0001 << w[11:8];
			for (int t = 0; t < 16 && !condHolds(w[31:28], f[3:0]); t++) begin
				f[3:0] = f[3:0] + 4'd1;  // Step to flags under which the condition holds
			end
			runSequence(w, f[3:0], f[3:0]);
		end
		repeat (40) begin  // Condition fails after the first transfer
			w = randWord();
			f = randWord();
			w[31:28] = w[31:28] % 4'd14;  // AL and NV never fail
			w[27:25] = 3'b100;
			w[1:0] = 2'b11;
			for (int t = 0; t < 16 && condHolds(w[31:28], f[3:0]); t++) begin
				f[3:0] = f[3:0] + 4'd1;  // Step to flags under which the condition fails
			end
			runSequence(w, f[7:4], f[3:0]);
		end
		@(negedge clk);
		$display("Run ended after %0d cycles with %0d errors", cycles, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
